// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////

    localparam int XLen = 32; // data, pc and immediate width.
    localparam int OpW = 6;

    ////////////////////////////////////////
    // architectural registers
    ////////////////////////////////////////

    localparam int RegNum = 32;
    localparam int NameW = 5;

    ////////////////////////////////////////
    // reorder buffer and rename tags
    ////////////////////////////////////////

    // entry count is a power of two so pointers wrap on their own.
    localparam int RobDepth = 8;
    localparam int RobIdxW = $clog2(RobDepth);

    // tag n names entry n-1, so one more bit than the index.
    localparam int TagW = 4;

    // value already in the register file.
    localparam logic [TagW-1:0] NoTag = '0;

    ////////////////////////////////////////
    // instruction queue
    ////////////////////////////////////////

    localparam int QueueDepth = 4; // default depth of instQueue.

endpackage

`default_nettype wire

// File: verilog/instQueue.sv
`timescale 1ns/1ns
`default_nettype none

module instQueue #(
    parameter int Depth = cpuPkg::QueueDepth
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clr,
    input  logic                     inValid,
    output logic                     inReady,
    input  logic [cpuPkg::OpW-1:0]   inOp,
    input  logic [cpuPkg::XLen-1:0]  inPc,
    input  logic [cpuPkg::XLen-1:0]  inImm,
    input  logic [cpuPkg::NameW-1:0] inRd,
    input  logic [cpuPkg::NameW-1:0] inRs1,
    input  logic [cpuPkg::NameW-1:0] inRs2,
    input  logic                     robFull,
    output logic                     issueEn,
    output logic [cpuPkg::OpW-1:0]   issueOp,
    output logic [cpuPkg::XLen-1:0]  issuePc,
    output logic [cpuPkg::XLen-1:0]  issueImm,
    output logic [cpuPkg::NameW-1:0] issueRd,
    output logic [cpuPkg::NameW-1:0] issueRs1,
    output logic [cpuPkg::NameW-1:0] issueRs2
);
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    logic [cpuPkg::OpW-1:0]   opQ  [Depth];
    logic [cpuPkg::XLen-1:0]  pcQ  [Depth];
    logic [cpuPkg::XLen-1:0]  immQ [Depth];
    logic [cpuPkg::NameW-1:0] rdQ  [Depth];
    logic [cpuPkg::NameW-1:0] rs1Q [Depth];
    logic [cpuPkg::NameW-1:0] rs2Q [Depth];
    logic [PtrW-1:0]          head;
    logic [PtrW-1:0]          tail;
    logic [CntW-1:0]          count;
    logic                     push;

    // depth need not be a power of two.
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        nextPtr = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign inReady = (count != CntW'(Depth));
    assign push = inValid && inReady;
    assign issueEn = (count != '0) && !robFull; // head leaves when the rob has room.

    assign issueOp  = opQ[head];
    assign issuePc  = pcQ[head];
    assign issueImm = immQ[head];
    assign issueRd  = rdQ[head];
    assign issueRs1 = rs1Q[head];
    assign issueRs2 = rs2Q[head];

    always_ff @(posedge clk) begin
        if (push) begin
            opQ[tail]  <= inOp;
            pcQ[tail]  <= inPc;
            immQ[tail] <= inImm;
            rdQ[tail]  <= inRd;
            rs1Q[tail] <= inRs1;
            rs2Q[tail] <= inRs2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push)
                tail <= nextPtr(tail);
            if (issueEn)
                head <= nextPtr(head);
            count <= count + CntW'(push) - CntW'(issueEn);
        end
    end

    // tail runs count entries ahead of head and never laps it.
    assert property (@(posedge clk) disable iff (rst || clr)
        (count <= CntW'(Depth)) && (32'(tail) == (32'(head) + 32'(count)) % Depth))
        else $error("instQueue: push while full or pointers out of step");

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clr,
    input  logic                     issueEn,
    input  logic [cpuPkg::OpW-1:0]   issueOp,
    input  logic [cpuPkg::XLen-1:0]  issuePc,
    input  logic [cpuPkg::XLen-1:0]  issueImm,
    input  logic [cpuPkg::NameW-1:0] issueRd,
    input  logic [cpuPkg::NameW-1:0] issueRs1,
    input  logic [cpuPkg::NameW-1:0] issueRs2,
    input  logic [cpuPkg::TagW-1:0]  allocTag,
    output logic                     dispEn,
    output logic [cpuPkg::TagW-1:0]  dispTag,
    output logic [cpuPkg::OpW-1:0]   dispOp,
    output logic [cpuPkg::XLen-1:0]  dispPc,
    output logic [cpuPkg::XLen-1:0]  dispImm,
    output logic [cpuPkg::NameW-1:0] dispRd,
    output logic [cpuPkg::XLen-1:0]  dispRs1Data,
    output logic [cpuPkg::TagW-1:0]  dispRs1Tag,
    output logic [cpuPkg::XLen-1:0]  dispRs2Data,
    output logic [cpuPkg::TagW-1:0]  dispRs2Tag,
    input  logic                     commitEn,
    input  logic [cpuPkg::NameW-1:0] commitRd,
    input  logic [cpuPkg::TagW-1:0]  commitTag,
    input  logic [cpuPkg::XLen-1:0]  commitData
);
    logic [cpuPkg::XLen-1:0] dataArr [cpuPkg::RegNum];
    logic [cpuPkg::TagW-1:0] tagArr  [cpuPkg::RegNum];
    logic                    commitWrite;
    logic                    commitMatch;

    ////////////////////////////////////////
    // operand read with commit bypass
    ////////////////////////////////////////

    assign commitWrite = commitEn && (commitRd != '0); // x0 is never written.
    assign commitMatch = commitWrite && (tagArr[commitRd] == commitTag);

    function automatic logic [cpuPkg::XLen-1:0] readData(
        input logic [cpuPkg::NameW-1:0] name
    );
        if (name == '0)
            readData = '0;
        else if (commitWrite && (name == commitRd))
            readData = commitData;
        else
            readData = dataArr[name];
    endfunction

    function automatic logic [cpuPkg::TagW-1:0] readTag(
        input logic [cpuPkg::NameW-1:0] name
    );
        if (name == '0)
            readTag = cpuPkg::NoTag;
        else if (commitMatch && (name == commitRd))
            readTag = cpuPkg::NoTag; // producer retires this cycle.
        else
            readTag = tagArr[name];
    endfunction

    ////////////////////////////////////////
    // architectural state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::RegNum; i++) begin
                dataArr[i] <= '0;
                tagArr[i]  <= cpuPkg::NoTag;
            end
        end else begin
            // commits arrive in program order, so the value is always the newest retired one.
            if (commitWrite)
                dataArr[commitRd] <= commitData;
            if (clr) begin
                for (int i = 0; i < cpuPkg::RegNum; i++)
                    tagArr[i] <= cpuPkg::NoTag;
            end else begin
                if (commitMatch)
                    tagArr[commitRd] <= cpuPkg::NoTag;
                if (issueEn && (issueRd != '0))
                    tagArr[issueRd] <= allocTag; // younger rename wins over the clear.
            end
        end
    end

    ////////////////////////////////////////
    // dispatch register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || clr || !issueEn) begin
            dispEn      <= 1'b0;
            dispTag     <= cpuPkg::NoTag;
            dispOp      <= '0;
            dispPc      <= '0;
            dispImm     <= '0;
            dispRd      <= '0;
            dispRs1Data <= '0;
            dispRs1Tag  <= cpuPkg::NoTag;
            dispRs2Data <= '0;
            dispRs2Tag  <= cpuPkg::NoTag;
        end else begin
            dispEn      <= 1'b1;
            dispTag     <= allocTag;
            dispOp      <= issueOp;
            dispPc      <= issuePc;
            dispImm     <= issueImm;
            dispRd      <= issueRd;
            dispRs1Data <= readData(issueRs1);
            dispRs1Tag  <= readTag(issueRs1);
            dispRs2Data <= readData(issueRs2);
            dispRs2Tag  <= readTag(issueRs2);
        end
    end

    // retiring entries always carry a real tag from the rob.
    assert property (@(posedge clk) disable iff (rst)
        commitEn |-> (commitTag != cpuPkg::NoTag))
        else $error("regFile: commit with NoTag");

endmodule

`default_nettype wire

// File: verilog/reorderBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module reorderBuffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clr,
    input  logic                     issueEn,
    input  logic [cpuPkg::NameW-1:0] issueRd,
    output logic [cpuPkg::TagW-1:0]  allocTag,
    output logic                     robFull,
    input  logic                     wbEn,
    input  logic [cpuPkg::TagW-1:0]  wbTag,
    input  logic [cpuPkg::XLen-1:0]  wbData,
    output logic                     commitEn,
    output logic [cpuPkg::NameW-1:0] commitRd,
    output logic [cpuPkg::TagW-1:0]  commitTag,
    output logic [cpuPkg::XLen-1:0]  commitData
);
    logic [cpuPkg::RobDepth-1:0]  busy;
    logic [cpuPkg::RobDepth-1:0]  done;
    logic [cpuPkg::NameW-1:0]     rdArr   [cpuPkg::RobDepth];
    logic [cpuPkg::XLen-1:0]      dataArr [cpuPkg::RobDepth];
    logic [cpuPkg::RobIdxW-1:0]   head;
    logic [cpuPkg::RobIdxW-1:0]   tail;
    logic [cpuPkg::RobIdxW:0]     count;
    logic [cpuPkg::RobIdxW-1:0]   wbIdx;
    logic                         commitNow;

    ////////////////////////////////////////
    // tags and status
    ////////////////////////////////////////

    // tag n lives in entry n-1.
    assign allocTag = cpuPkg::TagW'(tail) + cpuPkg::TagW'(1);
    assign wbIdx = cpuPkg::RobIdxW'(wbTag - cpuPkg::TagW'(1));

    assign robFull = (count == (cpuPkg::RobIdxW + 1)'(cpuPkg::RobDepth));
    assign commitNow = busy[head] && done[head]; // head retires once its result is in.

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            busy     <= '0;
            done     <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            commitEn <= 1'b0;
        end else begin
            commitEn <= commitNow;
            if (commitNow) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (issueEn) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (wbEn)
                done[wbIdx] <= 1'b1;
            count <= count + (cpuPkg::RobIdxW + 1)'(issueEn)
                           - (cpuPkg::RobIdxW + 1)'(commitNow);
        end
    end

    ////////////////////////////////////////
    // entry payload and commit port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (issueEn)
            rdArr[tail] <= issueRd;
        if (wbEn)
            dataArr[wbIdx] <= wbData;
        if (commitNow) begin
            commitRd   <= rdArr[head];
            commitTag  <= cpuPkg::TagW'(head) + cpuPkg::TagW'(1);
            commitData <= dataArr[head]; // valid only with commitEn.
        end
    end

    // the queue must hold its head back while the buffer is full.
    assert property (@(posedge clk) disable iff (rst || clr)
        issueEn |-> !robFull)
        else $error("reorderBuffer: allocation while full");

    // results come back once, and only for live entries.
    assert property (@(posedge clk) disable iff (rst || clr)
        wbEn |-> (busy[wbIdx] && !done[wbIdx]))
        else $error("reorderBuffer: writeback to idle or finished entry");

endmodule

`default_nettype wire

// File: verilog/renameCore.sv
`timescale 1ns/1ns
`default_nettype none

module renameCore (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clr,
    input  logic                     inValid,
    output logic                     inReady,
    input  logic [cpuPkg::OpW-1:0]   inOp,
    input  logic [cpuPkg::XLen-1:0]  inPc,
    input  logic [cpuPkg::XLen-1:0]  inImm,
    input  logic [cpuPkg::NameW-1:0] inRd,
    input  logic [cpuPkg::NameW-1:0] inRs1,
    input  logic [cpuPkg::NameW-1:0] inRs2,
    output logic                     dispEn,
    output logic [cpuPkg::TagW-1:0]  dispTag,
    output logic [cpuPkg::OpW-1:0]   dispOp,
    output logic [cpuPkg::XLen-1:0]  dispPc,
    output logic [cpuPkg::XLen-1:0]  dispImm,
    output logic [cpuPkg::NameW-1:0] dispRd,
    output logic [cpuPkg::XLen-1:0]  dispRs1Data,
    output logic [cpuPkg::TagW-1:0]  dispRs1Tag,
    output logic [cpuPkg::XLen-1:0]  dispRs2Data,
    output logic [cpuPkg::TagW-1:0]  dispRs2Tag,
    input  logic                     wbEn,
    input  logic [cpuPkg::TagW-1:0]  wbTag,
    input  logic [cpuPkg::XLen-1:0]  wbData,
    output logic                     commitEn,
    output logic [cpuPkg::NameW-1:0] commitRd,
    output logic [cpuPkg::TagW-1:0]  commitTag,
    output logic [cpuPkg::XLen-1:0]  commitData
);
    logic                     issueEn;
    logic [cpuPkg::OpW-1:0]   issueOp;
    logic [cpuPkg::XLen-1:0]  issuePc;
    logic [cpuPkg::XLen-1:0]  issueImm;
    logic [cpuPkg::NameW-1:0] issueRd;
    logic [cpuPkg::NameW-1:0] issueRs1;
    logic [cpuPkg::NameW-1:0] issueRs2;
    logic                     robFull;
    logic [cpuPkg::TagW-1:0]  allocTag;

    instQueue #(
        .Depth(cpuPkg::QueueDepth)
    ) instQueue0 (
        .clk, .rst, .clr,
        .inValid, .inReady,
        .inOp, .inPc, .inImm, .inRd, .inRs1, .inRs2,
        .robFull,
        .issueEn, .issueOp, .issuePc, .issueImm, .issueRd, .issueRs1, .issueRs2
    );

    regFile regFile0 (
        .clk, .rst, .clr,
        .issueEn, .issueOp, .issuePc, .issueImm, .issueRd, .issueRs1, .issueRs2,
        .allocTag,
        .dispEn, .dispTag, .dispOp, .dispPc, .dispImm, .dispRd,
        .dispRs1Data, .dispRs1Tag, .dispRs2Data, .dispRs2Tag,
        .commitEn, .commitRd, .commitTag, .commitData
    );

    reorderBuffer reorderBuffer0 (
        .clk, .rst, .clr,
        .issueEn, .issueRd,
        .allocTag, .robFull,
        .wbEn, .wbTag, .wbData,
        .commitEn, .commitRd, .commitTag, .commitData
    );

endmodule

`default_nettype wire

// File: test/renameCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module renameCoreTb;

    logic                     clk;
    logic                     rst;
    logic                     clr;
    logic                     inValid;
    logic                     inReady;
    logic [cpuPkg::OpW-1:0]   inOp;
    logic [cpuPkg::XLen-1:0]  inPc;
    logic [cpuPkg::XLen-1:0]  inImm;
    logic [cpuPkg::NameW-1:0] inRd;
    logic [cpuPkg::NameW-1:0] inRs1;
    logic [cpuPkg::NameW-1:0] inRs2;
    logic                     dispEn;
    logic [cpuPkg::TagW-1:0]  dispTag;
    logic [cpuPkg::OpW-1:0]   dispOp;
    logic [cpuPkg::XLen-1:0]  dispPc;
    logic [cpuPkg::XLen-1:0]  dispImm;
    logic [cpuPkg::NameW-1:0] dispRd;
    logic [cpuPkg::XLen-1:0]  dispRs1Data;
    logic [cpuPkg::TagW-1:0]  dispRs1Tag;
    logic [cpuPkg::XLen-1:0]  dispRs2Data;
    logic [cpuPkg::TagW-1:0]  dispRs2Tag;
    logic                     wbEn;
    logic [cpuPkg::TagW-1:0]  wbTag;
    logic [cpuPkg::XLen-1:0]  wbData;
    logic                     commitEn;
    logic [cpuPkg::NameW-1:0] commitRd;
    logic [cpuPkg::TagW-1:0]  commitTag;
    logic [cpuPkg::XLen-1:0]  commitData;

    int errors;
    int testCount;
    logic [31:0] rngState;
    logic [31:0] pcNext;

    // reference model of rename state.
    logic [cpuPkg::TagW-1:0] modelTag  [cpuPkg::RegNum];
    logic [31:0]             modelData [cpuPkg::RegNum];
    logic [31:0]              robData [16];
    logic [cpuPkg::TagW-1:0]  nextTag;

    // packed as tag, rd, pc, op, imm, r1 tag, r1 data, r2 tag, r2 data.
    logic [31:0] expDisp [$];
    logic [31:0] obsDisp [$];
    logic [cpuPkg::TagW-1:0] expCommit [$];
    logic [cpuPkg::NameW-1:0] expCommitRd [$];
    logic [31:0] obsCommit [$]; // tag, rd, data.

    renameCore dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 6 tests of at most 500 cycles each, plus margin.
    initial begin
        #(6 * 500 * 8 + 2000);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    ////////////////////////////////////////
    // monitors
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (dispEn) begin
            obsDisp.push_back(32'(dispTag));
            obsDisp.push_back(32'(dispRd));
            obsDisp.push_back(dispPc);
            obsDisp.push_back(32'(dispOp));
            obsDisp.push_back(dispImm);
            obsDisp.push_back(32'(dispRs1Tag));
            obsDisp.push_back(dispRs1Data);
            obsDisp.push_back(32'(dispRs2Tag));
            obsDisp.push_back(dispRs2Data);
        end
        if (commitEn) begin
            obsCommit.push_back(32'(commitTag));
            obsCommit.push_back(32'(commitRd));
            obsCommit.push_back(commitData);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timed out waiting for %s at %0t", what, $time);
        errors++;
    endtask

    task automatic clearModel();
        for (int i = 0; i < cpuPkg::RegNum; i++)
            modelTag[i] = cpuPkg::NoTag;
        nextTag = 4'd1;
        expDisp.delete();
        obsDisp.delete();
        expCommit.delete();
        expCommitRd.delete();
        obsCommit.delete();
    endtask

    ////////////////////////////////////////
    // stimulus tasks, each starts and ends at a falling edge
    ////////////////////////////////////////

    task automatic pushInst(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                            output logic [cpuPkg::TagW-1:0] tag);
        int waitCnt;
        waitCnt = 0;
        inValid = 1'b1;
        inOp = pcNext[7:2];
        inPc = pcNext;
        inImm = {27'd0, rd};
        inRd = rd;
        inRs1 = rs1;
        inRs2 = rs2;
        while (!inReady && waitCnt <= 100) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!inReady)
            reportTimeout("inReady");
        @(posedge clk);
        tag = nextTag;
        expDisp.push_back(32'(tag));
        expDisp.push_back(32'(rd));
        expDisp.push_back(pcNext);
        expDisp.push_back(32'(pcNext[7:2]));
        expDisp.push_back({27'd0, rd});
        expDisp.push_back(32'(rs1 == 0 ? cpuPkg::NoTag : modelTag[rs1]));
        expDisp.push_back(rs1 == 0 ? 32'd0 : modelData[rs1]);
        expDisp.push_back(32'(rs2 == 0 ? cpuPkg::NoTag : modelTag[rs2]));
        expDisp.push_back(rs2 == 0 ? 32'd0 : modelData[rs2]);
        if (rd != 0)
            modelTag[rd] = tag;
        expCommit.push_back(tag);
        expCommitRd.push_back(rd);
        nextTag = (nextTag == 4'(cpuPkg::RobDepth)) ? 4'd1 : nextTag + 4'd1;
        pcNext = pcNext + 32'd4;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic writeBack(input logic [cpuPkg::TagW-1:0] tag);
        rngState = xorshift(rngState);
        wbEn = 1'b1;
        wbTag = tag;
        wbData = rngState;
        robData[tag] = rngState;
        @(negedge clk);
        wbEn = 1'b0;
    endtask

    task automatic checkDispatch();
        int waitCnt;
        logic [31:0] e [9];
        logic [31:0] o [9];
        waitCnt = 0;
        while (obsDisp.size() == 0 && waitCnt <= 100) begin
            @(negedge clk);
            waitCnt++;
        end
        if (obsDisp.size() == 0) begin
            reportTimeout("dispatch");
        end else begin
            for (int i = 0; i < 9; i++) begin
                e[i] = expDisp.pop_front();
                o[i] = obsDisp.pop_front();
            end
            checkVal("dispTag", o[0], e[0]);
            checkVal("dispRd", o[1], e[1]);
            checkVal("dispPc", o[2], e[2]);
            checkVal("dispOp", o[3], e[3]);
            checkVal("dispImm", o[4], e[4]);
            checkVal("dispRs1Tag", o[5], e[5]);
            if (e[5] == 32'(cpuPkg::NoTag))
                checkVal("dispRs1Data", o[6], e[6]); // data only matters once ready.
            checkVal("dispRs2Tag", o[7], e[7]);
            if (e[7] == 32'(cpuPkg::NoTag))
                checkVal("dispRs2Data", o[8], e[8]);
        end
    endtask

    task automatic checkCommit();
        int waitCnt;
        logic [cpuPkg::TagW-1:0] t;
        logic [cpuPkg::NameW-1:0] rd;
        logic [31:0] gotTag;
        logic [31:0] gotRd;
        logic [31:0] gotData;
        waitCnt = 0;
        while (obsCommit.size() == 0 && waitCnt <= 100) begin
            @(negedge clk);
            waitCnt++;
        end
        if (obsCommit.size() == 0) begin
            reportTimeout("commit");
        end else begin
            gotTag = obsCommit.pop_front();
            gotRd = obsCommit.pop_front();
            gotData = obsCommit.pop_front();
            t = expCommit.pop_front();
            rd = expCommitRd.pop_front();
            checkVal("commitTag", gotTag, 32'(t));
            checkVal("commitRd", gotRd, 32'(rd));
            checkVal("commitData", gotData, robData[t]);
            if (rd != 0) begin
                modelData[rd] = robData[t];
                if (modelTag[rd] == t)
                    modelTag[rd] = cpuPkg::NoTag; // stale commits keep the newer tag.
            end
        end
    endtask

    task automatic endTest(input string name, input int errBefore);
        testCount++;
        $display("test %s finished with %0d errors", name, errors - errBefore);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic testReset();
        int e0;
        logic [cpuPkg::TagW-1:0] t;
        e0 = errors;
        checkVal("dispEn", 32'(dispEn), 32'd0);
        checkVal("commitEn", 32'(commitEn), 32'd0);
        checkVal("inReady", 32'(inReady), 32'd1);
        pushInst(5'd4, 5'd1, 5'd2, t);
        checkVal("dispEn", 32'(dispEn), 32'd0);
        @(negedge clk);
        checkVal("dispEn", 32'(dispEn), 32'd1); // second edge after acceptance.
        checkVal("dispTag", 32'(dispTag), 32'd1);
        checkDispatch();
        writeBack(t);
        checkCommit();
        endTest("reset", e0);
    endtask

    task automatic testRename();
        int e0;
        logic [cpuPkg::TagW-1:0] tw;
        logic [cpuPkg::TagW-1:0] tr;
        e0 = errors;
        pushInst(5'd5, 5'd0, 5'd0, tw);
        pushInst(5'd6, 5'd5, 5'd0, tr);
        checkDispatch();
        checkDispatch();
        writeBack(tw);
        writeBack(tr);
        checkCommit();
        checkCommit();
        endTest("rename", e0);
    endtask

    task automatic testInOrder();
        int e0;
        logic [cpuPkg::TagW-1:0] t [3];
        logic [cpuPkg::TagW-1:0] tr;
        e0 = errors;
        for (int i = 0; i < 3; i++)
            pushInst(5'(i + 1), 5'd0, 5'd0, t[i]);
        for (int i = 0; i < 3; i++)
            checkDispatch();
        for (int i = 2; i >= 0; i--)
            writeBack(t[i]);
        for (int i = 0; i < 3; i++)
            checkCommit();
        pushInst(5'd8, 5'd1, 5'd3, tr);
        checkDispatch();
        writeBack(tr);
        checkCommit();
        endTest("inOrder", e0);
    endtask

    task automatic testStale();
        int e0;
        logic [cpuPkg::TagW-1:0] ta;
        logic [cpuPkg::TagW-1:0] tb;
        logic [cpuPkg::TagW-1:0] tr;
        e0 = errors;
        pushInst(5'd7, 5'd0, 5'd0, ta);
        pushInst(5'd7, 5'd0, 5'd0, tb);
        checkDispatch();
        checkDispatch();
        writeBack(ta);
        checkCommit();
        pushInst(5'd9, 5'd7, 5'd0, tr);
        checkDispatch();
        writeBack(tb);
        writeBack(tr);
        checkCommit();
        checkCommit();
        pushInst(5'd9, 5'd7, 5'd0, tr);
        checkDispatch();
        writeBack(tr);
        checkCommit();
        endTest("stale", e0);
    endtask

    task automatic testBackPressure();
        int e0;
        logic [cpuPkg::TagW-1:0] t [12];
        e0 = errors;
        for (int i = 0; i < 8; i++)
            pushInst(5'(10 + i), 5'd0, 5'd0, t[i]);
        for (int i = 0; i < 8; i++)
            checkDispatch();
        for (int i = 8; i < 12; i++)
            pushInst(5'(10 + i), 5'd0, 5'd0, t[i]);
        checkVal("inReady", 32'(inReady), 32'd0);
        checkVal("dispEn", 32'(dispEn), 32'd0);
        for (int i = 0; i < 8; i++)
            writeBack(t[i]);
        for (int i = 0; i < 8; i++)
            checkCommit();
        for (int i = 8; i < 12; i++)
            checkDispatch();
        for (int i = 8; i < 12; i++)
            writeBack(t[i]);
        for (int i = 8; i < 12; i++)
            checkCommit();
        endTest("backPressure", e0);
    endtask

    task automatic testFlush();
        int e0;
        logic [cpuPkg::TagW-1:0] t;
        e0 = errors;
        pushInst(5'd3, 5'd0, 5'd0, t);
        pushInst(5'd1, 5'd3, 5'd0, t);
        checkDispatch();
        checkDispatch();
        clr = 1'b1;
        @(negedge clk);
        clr = 1'b0;
        checkVal("dispEn", 32'(dispEn), 32'd0);
        clearModel();
        pushInst(5'd2, 5'd3, 5'd1, t);
        checkDispatch();
        writeBack(t);
        checkCommit();
        endTest("flush", e0);
    endtask

    initial begin
        errors = 0;
        testCount = 0;
        rngState = 32'd16173;
        pcNext = 32'h1000;
        rst = 1'b1;
        clr = 1'b0;
        inValid = 1'b0;
        inOp = '0;
        inPc = '0;
        inImm = '0;
        inRd = '0;
        inRs1 = '0;
        inRs2 = '0;
        wbEn = 1'b0;
        wbTag = '0;
        wbData = '0;
        for (int i = 0; i < cpuPkg::RegNum; i++)
            modelData[i] = '0;
        clearModel();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testReset();
        testRename();
        testInOrder();
        testStale();
        testBackPressure();
        testFlush();
        $display("%0d tests run, %0d errors", testCount, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
verilog/cpuPkg.sv
verilog/instQueue.sv
verilog/regFile.sv
verilog/reorderBuffer.sv
verilog/renameCore.sv
test/renameCoreTb.sv

// File: run.sh
#!/bin/sh
# build and run the rename slice testbench with Verilator
set -e

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module renameCoreTb -o renameCoreSim
./obj_dir/renameCoreSim > sim.log 2>&1 || true
cat sim.log

grep -q "PASS: all tests" sim.log
echo "simulation passed"
